// ==== common/vout_macros.svh ====
// ##############################
// Output path widths, control word
// field positions and OSD palette
// ##############################

`ifndef VOUT_MACROS_SVH
`define VOUT_MACROS_SVH

// Channel and control word widths
`define VOUT_COLOR_W 8
`define VOUT_CTRL_W 32

// System control register fields
`define VOUT_POWERON_BIT 0
`define VOUT_EXTRA_MODE_LSB 26
`define VOUT_EXP_SEL_LSB 28

// OSD palette, {r, g, b}
`define VOUT_OSD_BLACK 24'h000000
`define VOUT_OSD_BLUE 24'h0000ff
`define VOUT_OSD_YELLOW 24'hffff00
`define VOUT_OSD_WHITE 24'hffffff

`endif

// ==== common/vout_pkg.sv ====
// ##############################
// Video, OSD, output control and
// VGA DAC types for the output path
// ##############################

`include "vout_macros.svh"

package vout_pkg;

    typedef struct packed {
        logic [`VOUT_COLOR_W-1:0] r;
        logic [`VOUT_COLOR_W-1:0] g;
        logic [`VOUT_COLOR_W-1:0] b;
    } pixel_t;

    typedef struct packed {
        pixel_t pix;
        logic   hsync;
        logic   vsync;
        logic   de;
    } video_t;

    typedef enum logic [1:0] {
        OSD_BLACK  = 2'd0,
        OSD_BLUE   = 2'd1,
        OSD_YELLOW = 2'd2,
        OSD_WHITE  = 2'd3
    } osd_color_e;

    typedef struct packed {
        logic       enable;
        osd_color_e color;
    } osd_t;

    // Sync format on the extra analog output
    typedef enum logic [1:0] {
        EXTRA_RGBHV = 2'd0,
        EXTRA_RGBCS = 2'd1,
        EXTRA_RGSB  = 2'd2,
        EXTRA_YPBPR = 2'd3
    } extra_mode_e;

    typedef enum logic [1:0] {
        EXP_OFF       = 2'd0,
        EXP_EXTRA_OUT = 2'd1,
        EXP_LEGACY_IN = 2'd2,
        EXP_UVC_BDG   = 2'd3
    } exp_sel_e;

    typedef struct packed {
        logic        poweron;
        exp_sel_e    exp_sel;
        extra_mode_e extra_mode;
    } out_ctrl_t;

    typedef struct packed {
        pixel_t pix;
        logic   hs;
        logic   vs;
        logic   blank_n;
        logic   sync_n;
    } vga_t;

endpackage

// ==== verilog/out_ctrl_decode.sv ====
// ##############################
// System control word sync into
// pclk_out and output setting decode
// ##############################

`timescale 1ns/1ps

`include "vout_macros.svh"

module out_ctrl_decode (
    input  logic                    pclk_out,
    input  logic                    po_reset_n,
    input  logic [`VOUT_CTRL_W-1:0] ctrl_word_i,
    output vout_pkg::out_ctrl_t     ctrl_o,
    output logic [1:0]              ls_dir_o,
    output logic                    psave_n_o
);

    vout_pkg::out_ctrl_t ctrl_raw;
    vout_pkg::out_ctrl_t ctrl_sync1;
    vout_pkg::out_ctrl_t ctrl_sync2;

    // Only the fields used by the output path are synchronized
    always_comb begin
        ctrl_raw.poweron = ctrl_word_i[`VOUT_POWERON_BIT];
        ctrl_raw.exp_sel =
            vout_pkg::exp_sel_e'(ctrl_word_i[`VOUT_EXP_SEL_LSB +: 2]);
        ctrl_raw.extra_mode =
            vout_pkg::extra_mode_e'(ctrl_word_i[`VOUT_EXTRA_MODE_LSB +: 2]);
    end

    // Word is quasi-static, written from another clock domain
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            ctrl_sync1 <= '0;
            ctrl_sync2 <= '0;
        end else begin
            ctrl_sync1 <= ctrl_raw;
            ctrl_sync2 <= ctrl_sync1;
        end
    end

    assign ctrl_o = ctrl_sync2;

    // Level shifter direction, 0=input 1=output
    assign ls_dir_o = (ctrl_sync2.exp_sel == vout_pkg::EXP_LEGACY_IN) ? 2'b10 : 2'b11;

    // DAC stays in power save until power-on
    assign psave_n_o = ctrl_sync2.poweron;

endmodule

// ==== osd_overlay/osd_overlay.sv ====
// ##############################
// OSD palette overlay on scaler
// video and HDMI TX output register
// ##############################

`timescale 1ns/1ps

`include "vout_macros.svh"

module osd_overlay (
    input  logic             pclk_out,
    input  logic             po_reset_n,
    input  vout_pkg::video_t vid_i,
    input  vout_pkg::osd_t   osd_i,
    output vout_pkg::video_t vid_s1_o,
    output vout_pkg::video_t hdmi_o
);

    vout_pkg::video_t vid_s1;
    vout_pkg::video_t vid_s2;
    vout_pkg::pixel_t osd_pix;

    always_comb begin
        case (osd_i.color)
            vout_pkg::OSD_BLACK:  osd_pix = vout_pkg::pixel_t'(`VOUT_OSD_BLACK);
            vout_pkg::OSD_BLUE:   osd_pix = vout_pkg::pixel_t'(`VOUT_OSD_BLUE);
            vout_pkg::OSD_YELLOW: osd_pix = vout_pkg::pixel_t'(`VOUT_OSD_YELLOW);
            default:              osd_pix = vout_pkg::pixel_t'(`VOUT_OSD_WHITE);
        endcase
    end

    // Stage 1: pixel replaced under OSD, timing signals untouched
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            vid_s1 <= '0;
        end else begin
            vid_s1.pix   <= osd_i.enable ? osd_pix : vid_i.pix;
            vid_s1.hsync <= vid_i.hsync;
            vid_s1.vsync <= vid_i.vsync;
            vid_s1.de    <= vid_i.de;
        end
    end

    // Stage 2: transmitter output register
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            vid_s2 <= '0;
        end else begin
            vid_s2 <= vid_s1;
        end
    end

    assign vid_s1_o = vid_s1;
    assign hdmi_o   = vid_s2;

endmodule

// ==== extra_out/extra_out_fmt.sv ====
// ##############################
// VGA DAC formatting on the expansion
// port: sync encoding per extra mode,
// pre and final stage, port enable
// ##############################

`timescale 1ns/1ps

module extra_out_fmt (
    input  logic                pclk_out,
    input  logic                po_reset_n,
    input  vout_pkg::out_ctrl_t ctrl_i,
    input  vout_pkg::video_t    vid_i,
    output vout_pkg::vga_t      ext_o,
    output logic                ext_oe_o
);

    vout_pkg::vga_t vga_pre;
    vout_pkg::vga_t vga_fin;
    vout_pkg::vga_t vga_enc;
    logic           ext_en;

    function automatic vout_pkg::vga_t encode_vga(
        input vout_pkg::video_t    v,
        input vout_pkg::extra_mode_e mode
    );
        vout_pkg::vga_t o;
        logic           csync;
        csync     = ~(v.hsync ^ v.vsync);
        o.pix     = v.pix;
        o.blank_n = v.de;
        case (mode)
            vout_pkg::EXTRA_RGBHV: begin
                o.hs     = v.hsync;
                o.vs     = v.vsync;
                o.sync_n = 1'b0;
            end
            vout_pkg::EXTRA_RGBCS: begin
                o.hs     = csync;
                o.vs     = 1'b1;
                o.sync_n = 1'b0;
            end
            // Sync on green / luma
            default: begin
                o.hs     = csync;
                o.vs     = 1'b1;
                o.sync_n = csync;
            end
        endcase
        return o;
    endfunction

    assign ext_en  = (ctrl_i.exp_sel == vout_pkg::EXP_EXTRA_OUT);
    assign vga_enc = encode_vga(vid_i, ctrl_i.extra_mode);

    // Both stages freeze while the port is used for something else
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            vga_pre <= '0;
            vga_fin <= '0;
        end else if (ext_en) begin
            vga_pre <= vga_enc;
            vga_fin <= vga_pre;
        end
    end

    assign ext_o    = vga_fin;
    assign ext_oe_o = ext_en;

endmodule

// ==== verilog/video_out_top.sv ====
// ##############################
// Output pixel path top level:
// control decode, OSD overlay with
// HDMI output, extra VGA output
// ##############################

`timescale 1ns/1ps

`include "vout_macros.svh"

module video_out_top (
    input  logic                    pclk_out,
    input  logic                    po_reset_n,
    input  logic [`VOUT_CTRL_W-1:0] ctrl_word_i,
    input  vout_pkg::video_t        vid_i,
    input  vout_pkg::osd_t          osd_i,
    output vout_pkg::video_t        hdmi_o,
    output vout_pkg::vga_t          ext_o,
    output logic                    ext_oe_o,
    output logic [1:0]              ls_dir_o,
    output logic                    psave_n_o
);

    vout_pkg::out_ctrl_t ctrl;
    vout_pkg::video_t    vid_s1;

    out_ctrl_decode u_ctrl_decode (
        .pclk_out    (pclk_out),
        .po_reset_n  (po_reset_n),
        .ctrl_word_i (ctrl_word_i),
        .ctrl_o      (ctrl),
        .ls_dir_o    (ls_dir_o),
        .psave_n_o   (psave_n_o)
    );

    osd_overlay u_osd_overlay (
        .pclk_out   (pclk_out),
        .po_reset_n (po_reset_n),
        .vid_i      (vid_i),
        .osd_i      (osd_i),
        .vid_s1_o   (vid_s1),
        .hdmi_o     (hdmi_o)
    );

    // VGA DAC taps the overlay stage, not the HDMI register
    extra_out_fmt u_extra_out (
        .pclk_out   (pclk_out),
        .po_reset_n (po_reset_n),
        .ctrl_i     (ctrl),
        .vid_i      (vid_s1),
        .ext_o      (ext_o),
        .ext_oe_o   (ext_oe_o)
    );

endmodule

// ==== sim/tb_clk_gen.sv ====
// ##############################
// Testbench clock, 20 ns period,
// and 16-cycle reset generator
// ##############################

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int half_period_ns = 10,
    parameter int reset_cycles   = 16
) (
    output logic pclk_out,
    output logic po_reset_n
);

    initial begin
        pclk_out = 1'b0;
        forever #(half_period_ns) pclk_out = ~pclk_out;
    end

    // Reset starts high so that a real falling edge reaches the flops
    initial begin
        po_reset_n = 1'b1;
        #1 po_reset_n = 1'b0;
        repeat (reset_cycles) @(posedge pclk_out);
        #2 po_reset_n = 1'b1;
    end

endmodule

// ==== sim/video_out_assert.sv ====
// ##############################
// Concurrent checks on the output
// path top level, bound to it
// ##############################

`timescale 1ns/1ps

`include "vout_macros.svh"

module video_out_assert (
    input logic                    pclk_out,
    input logic                    po_reset_n,
    input logic [`VOUT_CTRL_W-1:0] ctrl_word_i,
    input vout_pkg::video_t        hdmi_i,
    input vout_pkg::vga_t          ext_i,
    input logic                    ext_oe_i
);

    // Port enable trails the control word by the two synchronizer flops
    oe_follows_exp_sel: assert property (@(posedge pclk_out) disable iff (!po_reset_n)
        ext_oe_i ==
            ($past(ctrl_word_i[`VOUT_EXP_SEL_LSB +: 2], 2) == vout_pkg::EXP_EXTRA_OUT))
        else $error("ext_oe_o does not follow exp_sel of the control word");

    hdmi_zero_after_reset: assert property (@(posedge pclk_out)
        $rose(po_reset_n) |-> hdmi_i == '0)
        else $error("hdmi_o not zero after reset");

    // Port owned by another function, DAC data must not move
    ext_frozen_when_off: assert property (@(posedge pclk_out) disable iff (!po_reset_n)
        !ext_oe_i |=> $stable(ext_i))
        else $error("ext_o changed while ext_oe_o low");

endmodule

// ==== sim/video_out_tb.sv ====
// ##############################
// Output path testbench: stimulus,
// reference model, delayed compare,
// watchdog and result report
// ##############################

`timescale 1ns/1ps

`include "vout_macros.svh"

module video_out_tb;

    localparam logic [1:0] kind_skip = 2'd0;
    localparam logic [1:0] kind_chk  = 2'd1;
    localparam logic [1:0] kind_hold = 2'd2;

    localparam int flush_cycles = 4;
    localparam int n_rand       = 40;
    localparam int n_osd        = 6;
    localparam int n_mode       = 16;
    localparam int n_hold       = 12;
    localparam int total_cycles = 17 + 12 * flush_cycles + n_rand + 4 * n_osd
                                + 4 * (2 + n_mode) + (13 + n_hold) + 11;
    localparam int watchdog_ns  = (total_cycles + 100) * 20;

    logic                    pclk_out;
    logic                    po_reset_n;
    logic [`VOUT_CTRL_W-1:0] ctrl_word_i;
    vout_pkg::video_t        vid_i;
    vout_pkg::osd_t          osd_i;
    vout_pkg::video_t        hdmi_o;
    vout_pkg::vga_t          ext_o;
    logic                    ext_oe_o;
    logic [1:0]              ls_dir_o;
    logic                    psave_n_o;

    logic [`VOUT_CTRL_W-1:0] ctrl_next;
    integer                  seed = 55;
    string                   cur_test;
    int                      errors;
    int                      checks;
    int                      err_mark;
    int                      tests_run;
    int                      tests_failed;

    // Expected results waiting for the pipeline latency
    vout_pkg::video_t hdmi_q[$];
    bit               hdmi_chk_q[$];
    vout_pkg::vga_t   vga_q[$];
    logic [1:0]       vga_kind_q[$];
    vout_pkg::vga_t   last_vga_exp;

    tb_clk_gen u_clk_gen (
        .pclk_out   (pclk_out),
        .po_reset_n (po_reset_n)
    );

    video_out_top uut (
        .pclk_out    (pclk_out),
        .po_reset_n  (po_reset_n),
        .ctrl_word_i (ctrl_word_i),
        .vid_i       (vid_i),
        .osd_i       (osd_i),
        .hdmi_o      (hdmi_o),
        .ext_o       (ext_o),
        .ext_oe_o    (ext_oe_o),
        .ls_dir_o    (ls_dir_o),
        .psave_n_o   (psave_n_o)
    );

    bind video_out_top video_out_assert u_vout_assert (
        .pclk_out    (pclk_out),
        .po_reset_n  (po_reset_n),
        .ctrl_word_i (ctrl_word_i),
        .hdmi_i      (hdmi_o),
        .ext_i       (ext_o),
        .ext_oe_i    (ext_oe_o)
    );

    function automatic logic [`VOUT_CTRL_W-1:0] make_ctrl(
        input logic                  pwr,
        input vout_pkg::exp_sel_e    sel,
        input vout_pkg::extra_mode_e mode
    );
        logic [`VOUT_CTRL_W-1:0] w;
        w = '0;
        w[`VOUT_POWERON_BIT] = pwr;
        w[`VOUT_EXP_SEL_LSB +: 2] = sel;
        w[`VOUT_EXTRA_MODE_LSB +: 2] = mode;
        return w;
    endfunction

    function automatic vout_pkg::video_t rand_video();
        logic [31:0] r;
        r = $random(seed);
        return vout_pkg::video_t'(r[26:0]);
    endfunction

    function automatic vout_pkg::osd_t rand_osd();
        logic [31:0] r;
        r = $random(seed);
        return vout_pkg::osd_t'(r[2:0]);
    endfunction

    // Expected HDMI pixel and DAC word for one input cycle
    function automatic void ref_model(
        input  vout_pkg::video_t      v,
        input  vout_pkg::osd_t        o,
        input  vout_pkg::extra_mode_e mode,
        output vout_pkg::video_t      hdmi_exp,
        output vout_pkg::vga_t        vga_exp
    );
        logic [23:0] palette;
        logic        csync;
        case (o.color)
            vout_pkg::OSD_BLACK:  palette = `VOUT_OSD_BLACK;
            vout_pkg::OSD_BLUE:   palette = `VOUT_OSD_BLUE;
            vout_pkg::OSD_YELLOW: palette = `VOUT_OSD_YELLOW;
            default:              palette = `VOUT_OSD_WHITE;
        endcase
        hdmi_exp = v;
        if (o.enable) begin
            hdmi_exp.pix = palette;
        end
        csync = (v.hsync == v.vsync);
        vga_exp.pix     = hdmi_exp.pix;
        vga_exp.blank_n = v.de;
        if (mode == vout_pkg::EXTRA_RGBHV) begin
            vga_exp.hs     = v.hsync;
            vga_exp.vs     = v.vsync;
            vga_exp.sync_n = 1'b0;
        end else begin
            vga_exp.hs     = csync;
            vga_exp.vs     = 1'b1;
            vga_exp.sync_n = (mode == vout_pkg::EXTRA_RGBCS) ? 1'b0 : csync;
        end
    endfunction

    task automatic check_video(
        input string            name,
        input vout_pkg::video_t exp,
        input vout_pkg::video_t act
    );
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s hdmi_o: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_vga(
        input string          name,
        input vout_pkg::vga_t exp,
        input vout_pkg::vga_t act
    );
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s ext_o: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_ctrl(
        input logic [1:0] exp_ls_dir,
        input logic       exp_psave_n,
        input logic       exp_oe
    );
        checks++;
        if (ls_dir_o !== exp_ls_dir || psave_n_o !== exp_psave_n || ext_oe_o !== exp_oe) begin
            errors++;
            $display("Mismatch %s ls_dir/psave_n/oe: expected %b/%b/%b, actual %b/%b/%b",
                     cur_test, exp_ls_dir, exp_psave_n, exp_oe, ls_dir_o, psave_n_o, ext_oe_o);
        end
    endtask

    task automatic drive_cycle(
        input vout_pkg::video_t v,
        input vout_pkg::osd_t   o,
        input bit               hdmi_chk,
        input logic [1:0]       vga_kind
    );
        vout_pkg::video_t hdmi_exp;
        vout_pkg::vga_t   vga_exp;
        @(posedge pclk_out);
        #2;
        vid_i       = v;
        osd_i       = o;
        ctrl_word_i = ctrl_next;
        ref_model(v, o, vout_pkg::extra_mode_e'(ctrl_next[`VOUT_EXTRA_MODE_LSB +: 2]),
                  hdmi_exp, vga_exp);
        hdmi_q.push_back(hdmi_exp);
        hdmi_chk_q.push_back(hdmi_chk);
        vga_q.push_back(vga_exp);
        vga_kind_q.push_back(vga_kind);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = errors;
    endtask

    // Idle cycles drain the pipeline before the verdict
    task automatic end_test();
        int n_err;
        repeat (flush_cycles) drive_cycle('0, '0, 1'b0, kind_skip);
        n_err = errors - err_mark;
        tests_run++;
        if (n_err == 0) begin
            $display("PASS %s", cur_test);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", cur_test, n_err);
        end
    endtask

    // HDMI is 2 cycles behind the drive, the DAC 3 cycles
    always @(negedge pclk_out) begin : compare_outputs
        vout_pkg::video_t exp_video;
        vout_pkg::vga_t   exp_vga;
        bit               hdmi_chk;
        logic [1:0]       kind;
        if (hdmi_q.size() > 2) begin
            exp_video = hdmi_q.pop_front();
            hdmi_chk  = hdmi_chk_q.pop_front();
            if (hdmi_chk) begin
                check_video(cur_test, exp_video, hdmi_o);
            end
        end
        if (vga_q.size() > 3) begin
            exp_vga = vga_q.pop_front();
            kind    = vga_kind_q.pop_front();
            if (kind == kind_chk) begin
                check_vga(cur_test, exp_vga, ext_o);
                last_vga_exp = exp_vga;
            end else if (kind == kind_hold) begin
                check_vga(cur_test, last_vga_exp, ext_o);
            end
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("Timeout: run did not finish within %0d ns", watchdog_ns);
        $display("test failed");
        $finish;
    end

    initial begin : main_seq
        vout_pkg::osd_t osd;
        ctrl_word_i  = '0;
        vid_i        = '0;
        osd_i        = '0;
        ctrl_next    = '0;
        last_vga_exp = '0;
        errors       = 0;
        checks       = 0;
        err_mark     = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_test     = "startup";
        @(negedge po_reset_n);
        @(posedge po_reset_n);

        begin_test("reset_state");
        check_video(cur_test, '0, hdmi_o);
        check_vga(cur_test, '0, ext_o);
        check_ctrl(2'b11, 1'b0, 1'b0);
        end_test();

        // ext_o never enabled yet, so it must stay at its reset value
        begin_test("hdmi_passthrough");
        repeat (n_rand) drive_cycle(rand_video(), '0, 1'b1, kind_hold);
        end_test();

        for (int c = 0; c < 4; c++) begin
            begin_test($sformatf("osd_color_%0d", c));
            osd.enable = 1'b1;
            osd.color  = vout_pkg::osd_color_e'(c[1:0]);
            repeat (n_osd) drive_cycle(rand_video(), osd, 1'b1, kind_hold);
            end_test();
        end

        for (int m = 0; m < 4; m++) begin
            begin_test($sformatf("extra_mode_%0d", m));
            ctrl_next = make_ctrl(1'b0, vout_pkg::EXP_EXTRA_OUT,
                                  vout_pkg::extra_mode_e'(m[1:0]));
            repeat (2) drive_cycle(rand_video(), rand_osd(), 1'b1, kind_skip);
            drive_cycle(rand_video(), rand_osd(), 1'b1, kind_chk);
            check_ctrl(2'b11, 1'b0, 1'b1);
            repeat (n_mode - 1) drive_cycle(rand_video(), rand_osd(), 1'b1, kind_chk);
            end_test();
        end

        begin_test("legacy_hold");
        ctrl_next = make_ctrl(1'b0, vout_pkg::EXP_EXTRA_OUT, vout_pkg::EXTRA_RGBCS);
        repeat (2) drive_cycle(rand_video(), rand_osd(), 1'b1, kind_skip);
        repeat (8) drive_cycle(rand_video(), rand_osd(), 1'b1, kind_chk);
        ctrl_next = make_ctrl(1'b0, vout_pkg::EXP_LEGACY_IN, vout_pkg::EXTRA_RGBCS);
        drive_cycle(rand_video(), rand_osd(), 1'b1, kind_hold);
        check_ctrl(2'b11, 1'b0, 1'b1);
        drive_cycle(rand_video(), rand_osd(), 1'b1, kind_hold);
        check_ctrl(2'b11, 1'b0, 1'b1);
        drive_cycle(rand_video(), rand_osd(), 1'b1, kind_hold);
        check_ctrl(2'b10, 1'b0, 1'b0);
        repeat (n_hold) drive_cycle(rand_video(), rand_osd(), 1'b1, kind_hold);
        end_test();

        begin_test("poweron");
        ctrl_next = make_ctrl(1'b1, vout_pkg::EXP_OFF, vout_pkg::EXTRA_RGBHV);
        drive_cycle(rand_video(), rand_osd(), 1'b1, kind_skip);
        check_ctrl(2'b10, 1'b0, 1'b0);
        drive_cycle(rand_video(), rand_osd(), 1'b1, kind_skip);
        check_ctrl(2'b10, 1'b0, 1'b0);
        drive_cycle(rand_video(), rand_osd(), 1'b1, kind_skip);
        check_ctrl(2'b11, 1'b1, 1'b0);
        repeat (8) drive_cycle(rand_video(), rand_osd(), 1'b1, kind_skip);
        end_test();

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0 && checks > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+common
common/vout_pkg.sv
verilog/out_ctrl_decode.sv
osd_overlay/osd_overlay.sv
extra_out/extra_out_fmt.sv
verilog/video_out_top.sv
sim/tb_clk_gen.sv
sim/video_out_assert.sv
sim/video_out_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the output path testbench with Verilator
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
    --top-module video_out_tb -o video_out_sim > build.log 2>&1 \
    && ./obj_dir/video_out_sim > sim.log 2>&1 \
    || echo "Build or simulation exited with an error" >> sim.log
cat build.log sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0
